/* hdl/colorMapperPkg.sv */
//----------------------------
// screen geometry and layer codes
// glyph indices and palette
// fragment payload union and word width
//----------------------------
package colorMapperPkg;

	//----------------------------
	// geometry
	localparam int coordWidth = 10;    // screen coordinate bits
	localparam int tankSize = 16;      // tank box edge
	localparam int bulletSize = 4;     // bullet box edge
	localparam int heartRowY = 440;    // top row of the heart slots
	localparam int heartBaseX1 = 100;  // slot 0 of player 1
	localparam int heartBaseX2 = 420;  // slot 0 of player 2
	localparam int heartPitch = 20;    // slot spacing, text glyphs use it too
	localparam int maxLives = 5;
	localparam int textBaseX = 290;
	localparam int textY = 240;
	localparam int winnerX = 312;
	localparam int winnerY = 220;

	//----------------------------
	// layer codes
	localparam int layerWidth = 3;
	localparam logic [2:0] layerNone = 3'd0;
	localparam logic [2:0] layerTank = 3'd1;
	localparam logic [2:0] layerBullet = 3'd2;
	localparam logic [2:0] layerHeart = 3'd3;
	localparam logic [2:0] layerText = 3'd4;
	localparam logic [2:0] layerWinner = 3'd5;

	// glyph table slots, tank ones follow the direction code
	localparam logic [3:0] glyphTankLeft = 4'd0;   // dir 0
	localparam logic [3:0] glyphTankRight = 4'd1;  // dir 1
	localparam logic [3:0] glyphTankDown = 4'd2;   // dir 2
	localparam logic [3:0] glyphTankUp = 4'd3;     // dir 3, also the winner
	localparam logic [3:0] glyphHeart = 4'd4;
	localparam logic [3:0] glyphText0 = 4'd5;
	localparam logic [3:0] glyphText1 = 4'd6;
	localparam logic [3:0] glyphText2 = 4'd7;
	localparam logic [3:0] glyphText3 = 4'd8;

	//----------------------------
	// palette
	localparam logic [23:0] colorP1 = 24'hFF5500;
	localparam logic [23:0] colorP2 = 24'h2BA558;
	localparam logic [23:0] colorShield = 24'h0055FF;
	localparam logic [23:0] colorHit = 24'hFEFEFE;
	localparam logic [23:0] colorBullet1 = 24'hFFAA00;
	localparam logic [23:0] colorHeart = 24'hFF4B70;
	localparam logic [23:0] colorText = 24'hFEFEFE;
	localparam logic [23:0] colorPlayBg = 24'h000080;  // normal play
	localparam logic [23:0] colorOverBg = 24'h000060;  // game over
	localparam logic [23:0] colorBlack = 24'h000000;

	// payload bits, read per layer
	typedef union packed
	{
		struct packed
		{
			logic player;  // 0 for player 1
			logic shield;
			logic hit;
			logic pad;
		} actor;  // tanks and bullets
		struct packed
		{
			logic player;
			logic [2:0] spare;
		} ui;  // winner glyph and hearts
	} fragPayload_u;

	localparam int payloadWidth = $bits(fragPayload_u);
	// word is {blank, over, layer, payload}
	localparam int fragWidth = 2 + layerWidth + payloadWidth;

endpackage

/* hdl/glyphRom.sv */
//----------------------------
// glyphRom
// 16x16 glyph rows for tanks, heart and the end text
//----------------------------
`timescale 1ns/1ps

module glyphRom (
	input  logic [3:0] glyph,
	input  logic [3:0] row,
	output logic [15:0] rowBits  // msb is the leftmost pixel
);
	import colorMapperPkg::*;

	// tank with barrel at the top
	localparam logic [15:0] tankUp [16] = '{
		16'h0180, 16'h0180, 16'h0180, 16'h0180, 16'h318C, 16'h3FFC, 16'h3FFC, 16'h3FFC,
		16'h3FFC, 16'h3E7C, 16'h3FFC, 16'h3FFC, 16'h3FFC, 16'h3FFC, 16'h3FFC, 16'h300C
	};
	localparam logic [15:0] tankDown [16] = '{
		16'h300C, 16'h3FFC, 16'h3FFC, 16'h3FFC, 16'h3FFC, 16'h3FFC, 16'h3E7C, 16'h3FFC,
		16'h3FFC, 16'h3FFC, 16'h3FFC, 16'h318C, 16'h0180, 16'h0180, 16'h0180, 16'h0180
	};
	localparam logic [15:0] tankLeft [16] = '{
		16'h0000, 16'h0000, 16'h0FFF, 16'h0FFF, 16'h07FE, 16'h07FE, 16'h07FE, 16'hFFBE,
		16'hFFBE, 16'h07FE, 16'h07FE, 16'h07FE, 16'h0FFF, 16'h0FFF, 16'h0000, 16'h0000
	};
	localparam logic [15:0] tankRight [16] = '{
		16'h0000, 16'h0000, 16'hFFF0, 16'hFFF0, 16'h7FE0, 16'h7FE0, 16'h7FE0, 16'h7DFF,
		16'h7DFF, 16'h7FE0, 16'h7FE0, 16'h7FE0, 16'hFFF0, 16'hFFF0, 16'h0000, 16'h0000
	};
	localparam logic [15:0] heart [16] = '{
		16'h0000, 16'h1C38, 16'h3E7C, 16'h7FFE, 16'h7FFE, 16'h7FFE, 16'h3FFC, 16'h1FF8,
		16'h0FF0, 16'h07E0, 16'h03C0, 16'h0180, 16'h0000, 16'h0000, 16'h0000, 16'h0000
	};

	//----------------------------
	// end text, spells WINS
	localparam logic [15:0] textW [16] = '{
		16'h0000, 16'h0000, 16'h1818, 16'h1818, 16'h1818, 16'h1818, 16'h1818, 16'h1818,
		16'h1998, 16'h1998, 16'h1998, 16'h1998, 16'h1998, 16'h1E78, 16'h0000, 16'h0000
	};
	localparam logic [15:0] textI [16] = '{
		16'h0000, 16'h0000, 16'h0FF0, 16'h0FF0, 16'h03C0, 16'h03C0, 16'h03C0, 16'h03C0,
		16'h03C0, 16'h03C0, 16'h03C0, 16'h03C0, 16'h0FF0, 16'h0FF0, 16'h0000, 16'h0000
	};
	localparam logic [15:0] textN [16] = '{
		16'h0000, 16'h0000, 16'h1C18, 16'h1C18, 16'h1E18, 16'h1B18, 16'h1998, 16'h18D8,
		16'h1878, 16'h1838, 16'h1818, 16'h1818, 16'h1818, 16'h1818, 16'h0000, 16'h0000
	};
	localparam logic [15:0] textS [16] = '{
		16'h0000, 16'h0000, 16'h0FF8, 16'h1FF8, 16'h1800, 16'h1800, 16'h1FF0, 16'h0FF8,
		16'h0018, 16'h0018, 16'h0018, 16'h1FF8, 16'h1FF0, 16'h0000, 16'h0000, 16'h0000
	};

	always_comb
	begin
		case (glyph)
			glyphTankLeft:  rowBits = tankLeft[row];
			glyphTankRight: rowBits = tankRight[row];
			glyphTankDown:  rowBits = tankDown[row];
			glyphTankUp:    rowBits = tankUp[row];
			glyphHeart:     rowBits = heart[row];
			glyphText0:     rowBits = textW[row];
			glyphText1:     rowBits = textI[row];
			glyphText2:     rowBits = textN[row];
			glyphText3:     rowBits = textS[row];
			default:        rowBits = '0;  // unused slots draw nothing
		endcase
	end

endmodule

/* hdl/sceneHitTest.sv */
//----------------------------
// sceneHitTest
// finds the top visible layer of a pixel
// and registers it as a fragment
//----------------------------
`timescale 1ns/1ps

module sceneHitTest (
	input  logic Clk,
	input  logic rst,
	// request stream
	input  logic reqValid,
	output logic reqReady,
	input  logic [colorMapperPkg::coordWidth-1:0] drawX,
	input  logic [colorMapperPkg::coordWidth-1:0] drawY,
	input  logic blank,  // low while blanked
	// game state
	input  logic [colorMapperPkg::coordWidth-1:0] tank1X, tank1Y,
	input  logic [colorMapperPkg::coordWidth-1:0] tank2X, tank2Y,
	input  logic [1:0] tank1Dir, tank2Dir,
	input  logic [colorMapperPkg::coordWidth-1:0] bullet1X, bullet1Y,
	input  logic [colorMapperPkg::coordWidth-1:0] bullet2X, bullet2Y,
	input  logic bullet1On, bullet2On,
	input  logic [2:0] lives1, lives2,
	input  logic gameOver1, gameOver2,  // gameOver1 means player 1 won
	input  logic shield1, shield2,
	input  logic tank1Hit, tank2Hit,
	// fragment stream
	output logic fragValid,
	input  logic fragReady,
	output logic fragBlank,
	output logic fragOver,
	output logic [colorMapperPkg::layerWidth-1:0] fragLayer,
	output colorMapperPkg::fragPayload_u fragPayload
);
	import colorMapperPkg::*;

	localparam logic [coordWidth-1:0] glyphEdge = coordWidth'(16);

	logic gameOver;
	logic accept;
	logic inTank1, inTank2, inBullet1, inBullet2;
	logic [3:0] actorGlyph, actorRow, actorCol;
	logic [15:0] actorBits;
	logic actorHit;
	logic [3:0] uiGlyph, uiRow, uiCol;
	logic [15:0] uiBits;
	logic [layerWidth-1:0] uiLayer;
	logic uiPlayer;
	logic uiHit;
	logic [coordWidth-1:0] slotX;  // left edge of the slot under test
	logic [layerWidth-1:0] nextLayer;
	fragPayload_u nextPayload;

	// pixel inside a square box, no wrap past the screen edge
	function automatic logic inBox(
		input logic [coordWidth-1:0] px,
		input logic [coordWidth-1:0] py,
		input logic [coordWidth-1:0] bx,
		input logic [coordWidth-1:0] by,
		input logic [coordWidth-1:0] size
	);
		logic [coordWidth-1:0] dx;
		logic [coordWidth-1:0] dy;
		dx = px - bx;
		dy = py - by;
		return (px >= bx) && (py >= by) && (dx < size) && (dy < size);
	endfunction

	function automatic logic [3:0] dirGlyph(input logic [1:0] dir);
		case (dir)
			2'd0:    return glyphTankLeft;
			2'd1:    return glyphTankRight;
			2'd2:    return glyphTankDown;
			default: return glyphTankUp;
		endcase
	endfunction

	assign gameOver = gameOver1 | gameOver2;
	assign inTank1 = inBox(drawX, drawY, tank1X, tank1Y, coordWidth'(tankSize));
	assign inTank2 = inBox(drawX, drawY, tank2X, tank2Y, coordWidth'(tankSize));
	assign inBullet1 = bullet1On
		& inBox(drawX, drawY, bullet1X, bullet1Y, coordWidth'(bulletSize));
	assign inBullet2 = bullet2On
		& inBox(drawX, drawY, bullet2X, bullet2Y, coordWidth'(bulletSize));

	//----------------------------
	// actor glyph lookup
	// one rom for both tanks so tank 1's box hides tank 2's
	assign actorGlyph = inTank1 ? dirGlyph(tank1Dir) : dirGlyph(tank2Dir);
	assign actorRow = inTank1 ? 4'(drawY - tank1Y) : 4'(drawY - tank2Y);
	assign actorCol = inTank1 ? 4'(drawX - tank1X) : 4'(drawX - tank2X);
	assign actorHit = actorBits[4'(15 - actorCol)];  // leftmost pixel at bit 15

	glyphRom actorRom (.glyph(actorGlyph), .row(actorRow), .rowBits(actorBits));

	//----------------------------
	// ui glyph lookup
	// hearts in play, text and winner after the game
	always_comb
	begin
		uiGlyph = glyphHeart;
		uiRow = 4'(drawY - coordWidth'(heartRowY));
		uiCol = '0;
		uiLayer = layerNone;
		uiPlayer = 1'b0;
		slotX = '0;
		if (gameOver)
		begin
			for (int j = 0; j < 4; j++)
			begin
				slotX = coordWidth'(textBaseX + j * heartPitch);
				if (inBox(drawX, drawY, slotX, coordWidth'(textY), glyphEdge))
				begin
					uiGlyph = 4'(glyphText0 + j);
					uiRow = 4'(drawY - coordWidth'(textY));
					uiCol = 4'(drawX - slotX);
					uiLayer = layerText;
				end
			end
			if (inBox(drawX, drawY, coordWidth'(winnerX), coordWidth'(winnerY), glyphEdge))
			begin
				uiGlyph = glyphTankUp;  // winner is an upright tank
				uiRow = 4'(drawY - coordWidth'(winnerY));
				uiCol = 4'(drawX - coordWidth'(winnerX));
				uiLayer = layerWinner;
				uiPlayer = ~gameOver1;
			end
		end
		else
		begin
			// slot k lit only while lives > k
			for (int k = 0; k < maxLives; k++)
			begin
				slotX = coordWidth'(heartBaseX1 + k * heartPitch);
				if (lives1 > k && inBox(drawX, drawY, slotX, coordWidth'(heartRowY), glyphEdge))
				begin
					uiCol = 4'(drawX - slotX);
					uiLayer = layerHeart;
				end
				slotX = coordWidth'(heartBaseX2 + k * heartPitch);
				if (lives2 > k && inBox(drawX, drawY, slotX, coordWidth'(heartRowY), glyphEdge))
				begin
					uiCol = 4'(drawX - slotX);
					uiLayer = layerHeart;
					uiPlayer = 1'b1;
				end
			end
		end
	end

	assign uiHit = (uiLayer != layerNone) && uiBits[4'(15 - uiCol)];

	glyphRom uiRom (.glyph(uiGlyph), .row(uiRow), .rowBits(uiBits));

	// layer priority, tanks on top
	always_comb
	begin
		nextLayer = layerNone;
		nextPayload = '0;
		if (gameOver)
		begin
			if (uiHit)
			begin
				nextLayer = uiLayer;
				nextPayload.ui.player = uiPlayer;
			end
		end
		else if (inTank1 && actorHit)
		begin
			nextLayer = layerTank;
			nextPayload.actor.shield = shield1;
			nextPayload.actor.hit = tank1Hit;
		end
		else if (inTank2 && actorHit)
		begin
			nextLayer = layerTank;
			nextPayload.actor.player = 1'b1;
			nextPayload.actor.shield = shield2;
			nextPayload.actor.hit = tank2Hit;
		end
		else if (inBullet1)
			nextLayer = layerBullet;
		else if (inBullet2)
		begin
			nextLayer = layerBullet;
			nextPayload.actor.player = 1'b1;
		end
		else if (uiHit)
		begin
			nextLayer = layerHeart;
			nextPayload.ui.player = uiPlayer;
		end
	end

	//----------------------------
	// output register
	assign reqReady = ~fragValid | fragReady;  // empty or draining
	assign accept = reqValid & reqReady;

	always_ff @(posedge Clk)
	begin
		if (rst)
			fragValid <= 1'b0;
		else if (reqReady)
			fragValid <= reqValid;
	end

	always_ff @(posedge Clk)
	begin
		if (accept)
		begin
			fragBlank <= blank;
			fragOver <= gameOver;
			fragLayer <= nextLayer;
			fragPayload <= nextPayload;
		end
	end

endmodule

/* hdl/fragmentFifo.sv */
//----------------------------
// fragmentFifo
// circular valid/ready buffer
//----------------------------
`timescale 1ns/1ps

module fragmentFifo #(
	parameter int depth = 4,      // entries
	parameter int dataWidth = 8   // bits per entry
) (
	input  logic Clk,
	input  logic rst,
	input  logic inValid,
	input  logic [dataWidth-1:0] inWord,
	output logic inReady,
	output logic outValid,
	output logic [dataWidth-1:0] outWord,
	input  logic outReady
);
	localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
	localparam int cntWidth = $clog2(depth + 1);

	logic [dataWidth-1:0] mem [depth];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [cntWidth-1:0] count;  // occupancy
	logic doWrite;
	logic doRead;

	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
		return (ptr == ptrWidth'(depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign outValid = (count != '0);
	assign outWord = mem[rdPtr];  // head entry
	// when full a write goes in only beside a read
	assign inReady = (count != cntWidth'(depth)) | outReady;
	assign doWrite = inValid & inReady;
	assign doRead = outValid & outReady;

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= nextPtr(wrPtr);
			if (doRead)
				rdPtr <= nextPtr(rdPtr);
			case ({doWrite, doRead})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // none or both
			endcase
		end
	end

	always_ff @(posedge Clk)
	begin
		if (doWrite)
			mem[wrPtr] <= inWord;
	end

endmodule

/* hdl/pixelShader.sv */
//----------------------------
// pixelShader
// fragment to registered rgb
//----------------------------
`timescale 1ns/1ps

module pixelShader (
	input  logic Clk,
	input  logic rst,
	input  logic bufValid,
	input  logic [colorMapperPkg::fragWidth-1:0] bufWord,
	output logic bufReady,
	output logic pixValid,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue,
	input  logic pixReady
);
	import colorMapperPkg::*;

	logic wordBlank;
	logic wordOver;
	logic [layerWidth-1:0] wordLayer;
	fragPayload_u payload;
	logic [23:0] shade;   // colour for the word at the head
	logic [23:0] rgbReg;

	// word is {blank, over, layer, payload}
	assign wordBlank = bufWord[fragWidth-1];
	assign wordOver = bufWord[fragWidth-2];
	assign wordLayer = bufWord[payloadWidth +: layerWidth];
	assign payload = bufWord[payloadWidth-1:0];

	always_comb
	begin
		if (!wordBlank)
			shade = colorBlack;
		else if (wordOver)
		begin
			case (wordLayer)
				layerText:   shade = colorText;
				layerWinner: shade = payload.ui.player ? colorP2 : colorP1;
				default:     shade = colorOverBg;
			endcase
		end
		else
		begin
			case (wordLayer)
				layerTank:
				begin
					if (payload.actor.shield)
						shade = colorShield;  // shield beats the hit flash
					else if (payload.actor.hit)
						shade = colorHit;
					else
						shade = payload.actor.player ? colorP2 : colorP1;
				end
				layerBullet: shade = payload.actor.player ? colorP2 : colorBullet1;
				layerHeart:  shade = colorHeart;
				default:     shade = colorPlayBg;
			endcase
		end
	end

	//----------------------------
	// output register
	assign bufReady = ~pixValid | pixReady;

	always_ff @(posedge Clk)
	begin
		if (rst)
			pixValid <= 1'b0;
		else if (bufReady)
			pixValid <= bufValid;
	end

	always_ff @(posedge Clk)
	begin
		if (bufValid & bufReady)
			rgbReg <= shade;
	end

	assign red = rgbReg[23:16];
	assign green = rgbReg[15:8];
	assign blue = rgbReg[7:0];

endmodule

/* hdl/colorMapper.sv */
//----------------------------
// colorMapper
// hit test, fragment buffer and shader in a row
//----------------------------
`timescale 1ns/1ps

module colorMapper #(
	parameter int fifoDepth = 4  // fragment buffer entries
) (
	input  logic Clk,
	input  logic rst,
	// pixel requests
	input  logic reqValid,
	output logic reqReady,
	input  logic [colorMapperPkg::coordWidth-1:0] drawX, drawY,
	input  logic blank,
	// game state
	input  logic [colorMapperPkg::coordWidth-1:0] tank1X, tank1Y, tank2X, tank2Y,
	input  logic [1:0] tank1Dir, tank2Dir,
	input  logic [colorMapperPkg::coordWidth-1:0] bullet1X, bullet1Y, bullet2X, bullet2Y,
	input  logic bullet1On, bullet2On,
	input  logic [2:0] lives1, lives2,
	input  logic gameOver1, gameOver2,
	input  logic shield1, shield2,
	input  logic tank1Hit, tank2Hit,
	// colour out
	output logic pixValid,
	input  logic pixReady,
	output logic [7:0] red, green, blue
);
	import colorMapperPkg::*;

	logic fragValid;
	logic fragReady;
	logic fragBlank;
	logic fragOver;
	logic [layerWidth-1:0] fragLayer;
	fragPayload_u fragPayload;
	logic [fragWidth-1:0] fragWord;
	logic bufValid;
	logic bufReady;
	logic [fragWidth-1:0] bufWord;

	// producer
	sceneHitTest hitTest (
		.Clk(Clk), .rst(rst),
		.reqValid(reqValid), .reqReady(reqReady),
		.drawX(drawX), .drawY(drawY), .blank(blank),
		.tank1X(tank1X), .tank1Y(tank1Y), .tank2X(tank2X), .tank2Y(tank2Y),
		.tank1Dir(tank1Dir), .tank2Dir(tank2Dir),
		.bullet1X(bullet1X), .bullet1Y(bullet1Y), .bullet2X(bullet2X), .bullet2Y(bullet2Y),
		.bullet1On(bullet1On), .bullet2On(bullet2On),
		.lives1(lives1), .lives2(lives2),
		.gameOver1(gameOver1), .gameOver2(gameOver2),
		.shield1(shield1), .shield2(shield2),
		.tank1Hit(tank1Hit), .tank2Hit(tank2Hit),
		.fragValid(fragValid), .fragReady(fragReady),
		.fragBlank(fragBlank), .fragOver(fragOver),
		.fragLayer(fragLayer), .fragPayload(fragPayload)
	);

	assign fragWord = {fragBlank, fragOver, fragLayer, fragPayload};  // shader splits it back

	fragmentFifo #(.depth(fifoDepth), .dataWidth(fragWidth)) fragBuf (
		.Clk(Clk), .rst(rst),
		.inValid(fragValid), .inWord(fragWord), .inReady(fragReady),
		.outValid(bufValid), .outWord(bufWord), .outReady(bufReady)
	);

	// consumer
	pixelShader shader (
		.Clk(Clk), .rst(rst),
		.bufValid(bufValid), .bufWord(bufWord), .bufReady(bufReady),
		.pixValid(pixValid), .red(red), .green(green), .blue(blue),
		.pixReady(pixReady)
	);

endmodule

/* verification/colorMapper_asserts.sv */
//----------------------------
// handshake assertions, bound to the top level
//----------------------------
`timescale 1ns/1ps

module colorMapperAsserts (
	input logic Clk,
	input logic rst,
	input logic reqValid,
	input logic reqReady,
	input logic [colorMapperPkg::coordWidth-1:0] drawX,
	input logic [colorMapperPkg::coordWidth-1:0] drawY,
	input logic blank,
	input logic fragValid,
	input logic fragReady,
	input logic bufValid,
	input logic pixValid,
	input logic pixReady,
	input logic [7:0] red,
	input logic [7:0] green,
	input logic [7:0] blue
);
	int failCount = 0;  // read by the testbench

	// valids cleared by reset
	resetClears: assert property (@(posedge Clk) rst |=> !pixValid && !fragValid && !bufValid)
	else
	begin
		$error("valid high after a reset cycle");
		failCount++;
	end

	// stalled colour holds
	pixHolds: assert property (@(posedge Clk) disable iff (rst)
		pixValid && !pixReady |=> pixValid && $stable({red, green, blue}))
	else
	begin
		$error("pixel output changed while stalled");
		failCount++;
	end

	fragHolds: assert property (@(posedge Clk) disable iff (rst)
		fragValid && !fragReady |=> fragValid)
	else
	begin
		$error("fragment valid dropped while stalled");
		failCount++;
	end

	// request kept until taken
	reqHolds: assert property (@(posedge Clk) disable iff (rst)
		reqValid && !reqReady |=> reqValid && $stable({drawX, drawY, blank}))
	else
	begin
		$error("request dropped or changed before acceptance");
		failCount++;
	end

endmodule

/* verification/colorMapperTb.sv */
//----------------------------
// testbench for the colour pipeline
// file driven requests, random pixReady
// in-order colour checks and watchdog
//----------------------------
`timescale 1ns/1ps

module colorMapperTb;
	import colorMapperPkg::*;

	localparam int clkHalf = 4;       // 8 ns clock
	localparam int resetCycles = 4;
	localparam string testFile = "verification/colorMapper_tests.txt";

	logic Clk;
	logic rst;
	logic reqValid;
	logic reqReady;
	logic [coordWidth-1:0] drawX, drawY;
	logic blank;
	logic [coordWidth-1:0] tank1X, tank1Y, tank2X, tank2Y;
	logic [1:0] tank1Dir, tank2Dir;
	logic [coordWidth-1:0] bullet1X, bullet1Y, bullet2X, bullet2Y;
	logic bullet1On, bullet2On;
	logic [2:0] lives1, lives2;
	logic gameOver1, gameOver2;
	logic shield1, shield2;
	logic tank1Hit, tank2Hit;
	logic pixValid;
	logic pixReady;
	logic [7:0] red, green, blue;

	string records[$];            // S and P lines in file order
	logic [43:0] expected[$];     // {x, y, rgb} per accepted request
	logic [31:0] rngState;
	logic loaded;
	int pixTotal;
	int pixSent;
	int pixChecked;
	int mismatchCount;
	int otherCount;
	int totalErrors;

	colorMapper #(.fifoDepth(4)) i_colorMapper (.*);

	bind colorMapper colorMapperAsserts handshakeChecks (
		.Clk(Clk), .rst(rst),
		.reqValid(reqValid), .reqReady(reqReady),
		.drawX(drawX), .drawY(drawY), .blank(blank),
		.fragValid(fragValid), .fragReady(fragReady), .bufValid(bufValid),
		.pixValid(pixValid), .pixReady(pixReady),
		.red(red), .green(green), .blue(blue)
	);

	initial Clk = 1'b0;
	always #clkHalf Clk = ~Clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// random back-pressure about one low cycle in four
	always @(negedge Clk)
	begin
		rngState = xorshift(rngState);
		pixReady = (rngState[1:0] != 2'b00);
	end

	task automatic loadTests();
		int fd;
		string line;
		fd = $fopen(testFile, "r");
		if (fd == 0)
		begin
			$display("cannot open the test file %s", testFile);
			otherCount++;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && (line.getc(0) == "S" || line.getc(0) == "P"))
			begin
				records.push_back(line);
				if (line.getc(0) == "P")
					pixTotal++;
			end
		end
		$fclose(fd);
	endtask

	//----------------------------
	// stimulus tasks
	task automatic applyState(input string line);
		int v[20];
		int n;
		n = $sscanf(line, "S %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
			v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
			v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19]);
		if (n != 20)
		begin
			$display("state record has %0d fields instead of 20: %s", n, line);
			otherCount++;
			return;
		end
		@(negedge Clk);
		reqValid = 1'b0;  // state only moves between requests
		tank1X = coordWidth'(v[0]);
		tank1Y = coordWidth'(v[1]);
		tank2X = coordWidth'(v[2]);
		tank2Y = coordWidth'(v[3]);
		tank1Dir = 2'(v[4]);
		tank2Dir = 2'(v[5]);
		bullet1X = coordWidth'(v[6]);
		bullet1Y = coordWidth'(v[7]);
		bullet2X = coordWidth'(v[8]);
		bullet2Y = coordWidth'(v[9]);
		bullet1On = (v[10] != 0);
		bullet2On = (v[11] != 0);
		lives1 = 3'(v[12]);
		lives2 = 3'(v[13]);
		gameOver1 = (v[14] != 0);
		gameOver2 = (v[15] != 0);
		shield1 = (v[16] != 0);
		shield2 = (v[17] != 0);
		tank1Hit = (v[18] != 0);
		tank2Hit = (v[19] != 0);
	endtask

	task automatic sendPixel(input string line);
		int x, y, b;
		logic [23:0] rgb;
		int n;
		n = $sscanf(line, "P %d %d %d %h", x, y, b, rgb);
		if (n != 4)
		begin
			$display("pixel record has %0d fields instead of 4: %s", n, line);
			otherCount++;
			return;
		end
		@(negedge Clk);
		reqValid = 1'b1;
		drawX = coordWidth'(x);
		drawY = coordWidth'(y);
		blank = b[0];
		@(posedge Clk);
		while (!reqReady)
			@(posedge Clk);  // held until taken
		expected.push_back({drawX, drawY, rgb});
		pixSent++;
	endtask

	//----------------------------
	// output monitor
	always @(posedge Clk)
	begin : monitor
		logic [43:0] head;
		if (!rst && pixValid && pixReady)
		begin
			assert (expected.size() != 0)
			else
			begin
				$display("a colour came out with no request pending");
				otherCount++;
			end
			if (expected.size() != 0)
			begin
				head = expected.pop_front();
				assert ({red, green, blue} == head[23:0])
				else
				begin
					mismatchCount++;
					$display("MISMATCH {red,green,blue} x=%0d y=%0d: got %h expected %h",
						head[43:34], head[33:24], {red, green, blue}, head[23:0]);
				end
				pixChecked++;
			end
		end
	end

	initial
	begin
		rst = 1'b1;
		reqValid = 1'b0;
		drawX = '0;
		drawY = '0;
		blank = 1'b0;
		tank1X = '0;
		tank1Y = '0;
		tank2X = '0;
		tank2Y = '0;
		tank1Dir = '0;
		tank2Dir = '0;
		bullet1X = '0;
		bullet1Y = '0;
		bullet2X = '0;
		bullet2Y = '0;
		bullet1On = 1'b0;
		bullet2On = 1'b0;
		lives1 = '0;
		lives2 = '0;
		gameOver1 = 1'b0;
		gameOver2 = 1'b0;
		shield1 = 1'b0;
		shield2 = 1'b0;
		tank1Hit = 1'b0;
		tank2Hit = 1'b0;
		pixReady = 1'b0;
		rngState = 32'h8cfe048f;
		loaded = 1'b0;
		pixTotal = 0;
		pixSent = 0;
		pixChecked = 0;
		mismatchCount = 0;
		otherCount = 0;
		loadTests();
		loaded = 1'b1;
		repeat (resetCycles) @(posedge Clk);
		@(negedge Clk);
		rst = 1'b0;
		foreach (records[i])
		begin
			if (records[i].getc(0) == "S")
				applyState(records[i]);
			else
				sendPixel(records[i]);
		end
		@(negedge Clk);
		reqValid = 1'b0;
		wait (pixChecked == pixSent);  // pipeline drained
		@(posedge Clk);
		totalErrors = mismatchCount + otherCount + i_colorMapper.handshakeChecks.failCount;
		$display("checked %0d of %0d pixels: %0d mismatches, %0d other errors, %0d %s",
			pixChecked, pixTotal, mismatchCount, otherCount,
			i_colorMapper.handshakeChecks.failCount, "assertion fails");
		if (totalErrors == 0 && pixTotal > 0 && pixChecked == pixTotal)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// watchdog with 20 cycles per pixel plus slack
	initial
	begin
		wait (loaded);
		repeat (pixTotal * 20 + 200) @(posedge Clk);
		$display("timeout with %0d of %0d pixels checked, %0d mismatches, %0d other errors",
			pixChecked, pixTotal, mismatchCount, otherCount);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* verification/colorMapper_tests.txt */
# S t1x t1y t2x t2y dir1 dir2 b1x b1y b2x b2y b1on b2on lives1 lives2 over1 over2 sh1 sh2 hit1 hit2
# P drawX drawY blank rgb   (coordinates decimal, rgb hex, blank low means blanked)
# tank 1 up, tank 2 left
S 100 100 200 100 3 0 0 0 0 0 0 0 3 3 0 0 0 0 0 0
P 107 100 1 FF5500
P 100 100 1 000080
P 102 104 1 FF5500
P 104 104 1 000080
P 200 107 1 2BA558
P 209 107 1 000080
P 205 100 1 000080
# tank 1 right, tank 2 down
S 100 100 200 100 1 2 0 0 0 0 0 0 3 3 0 0 0 0 0 0
P 100 107 1 000080
P 101 107 1 FF5500
P 106 107 1 000080
P 107 107 1 FF5500
P 207 115 1 2BA558
P 200 115 1 000080
P 202 100 1 2BA558
P 201 100 1 000080
# tints: shield over hit over player colour
S 100 100 200 100 3 3 0 0 0 0 0 0 3 3 0 0 1 0 1 1
P 107 100 1 0055FF
P 207 100 1 FEFEFE
P 200 100 1 000080
S 100 100 200 100 3 3 0 0 0 0 0 0 3 3 0 0 0 1 1 1
P 107 100 1 FEFEFE
P 207 100 1 0055FF
# tank over bullets, bullet 1 over bullet 2
S 100 100 200 100 3 0 106 101 107 100 1 1 3 3 0 0 0 0 0 0
P 107 100 1 FF5500
P 106 101 1 FFAA00
P 109 102 1 FFAA00
P 110 102 1 2BA558
# hearts against lives, bullets over hearts
S 500 200 600 200 3 3 104 442 424 443 1 1 2 1 0 0 0 0 0 0
P 104 442 1 FFAA00
P 124 442 1 FF4B70
P 144 442 1 000080
P 120 442 1 000080
P 424 442 1 FF4B70
P 424 443 1 2BA558
P 444 442 1 000080
P 107 100 0 000000
# game over, player 1 wins
S 100 100 200 100 3 0 0 0 0 0 0 0 3 3 1 0 0 0 0 0
P 107 100 1 000060
P 293 242 1 FEFEFE
P 290 242 1 000060
P 314 242 1 FEFEFE
P 335 242 1 FEFEFE
P 354 242 1 FEFEFE
P 351 242 1 000060
P 319 220 1 FF5500
P 312 220 1 000060
P 124 442 1 000060
P 293 242 0 000000
# game over, player 2 wins
S 100 100 200 100 3 0 0 0 0 0 0 0 3 3 0 1 0 0 0 0
P 319 220 1 2BA558
P 319 221 1 2BA558
P 293 242 1 FEFEFE

/* sources.f */
hdl/colorMapperPkg.sv
hdl/glyphRom.sv
hdl/sceneHitTest.sv
hdl/fragmentFifo.sv
hdl/pixelShader.sv
hdl/colorMapper.sv
verification/colorMapper_asserts.sv
verification/colorMapperTb.sv
